/* design/rs5_consts.svh */
//////////////////////////////
// RS5 core constants
// Widths, reset PC and the RV32I opcodes used by the core
//////////////////////////////

`ifndef RS5_CONSTS_SVH
`define RS5_CONSTS_SVH

// Datapath
`define RS5_XLEN       32
`define RS5_REG_COUNT  32
`define RS5_RESET_PC   32'h0000_0000
`define RS5_TAG_W      3

// Major opcodes, instruction bits 6:0
`define RS5_OP_LUI     7'b0110111
`define RS5_OP_OPIMM   7'b0010011
`define RS5_OP_OP      7'b0110011
`define RS5_OP_LOAD    7'b0000011
`define RS5_OP_STORE   7'b0100011
`define RS5_OP_BRANCH  7'b1100011
`define RS5_OP_JAL     7'b1101111

`endif

/* design/rs5_pkg.sv */
//////////////////////////////
// RS5 shared types
// Vector typedefs and the internal operation encoding
//////////////////////////////

`default_nettype none

`include "rs5_consts.svh"

package rs5_pkg;

    // Data word and address
    typedef logic [`RS5_XLEN-1:0]  word_t;
    // Register index
    typedef logic [4:0]            reg_addr_t;
    // Jump tag, bumped on every taken jump
    typedef logic [`RS5_TAG_W-1:0] tag_t;
    // Data memory byte write strobes
    typedef logic [3:0]            byte_en_t;

    // Operation carried from decode to retire
    typedef enum logic [3:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        SRA,
        LUI,
        LOAD,
        STORE,
        BEQ,
        BNE,
        JAL
    } iop_e;

endpackage

`default_nettype wire

/* design/rs5_fetch.sv */
//////////////////////////////
// RS5 fetch stage
// Program counter, jump redirect and jump tag counter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_consts.svh"

module rs5_fetch (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           enable_i,
    input  logic           jump_i,
    input  rs5_pkg::word_t jump_target_i,
    output rs5_pkg::word_t instruction_address_o,
    output rs5_pkg::word_t pc_o,
    output rs5_pkg::tag_t  tag_o
);
    import rs5_pkg::*;

    // Next address to fetch
    word_t pc;
    // Tag of the current program path
    tag_t  tag;

    // Held cycles re-present the decode address
    // so the same word comes back next cycle
    assign instruction_address_o = enable_i ? pc : pc_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc  <= `RS5_RESET_PC;
            tag <= '0;
        end else if (jump_i) begin
            pc  <= jump_target_i;
            tag <= tag + 1'b1;
        end else if (enable_i) begin
            pc  <= pc + 32'd4;
        end
    end

    // Address and tag paired with the returning word
    // Reset tag is one behind so the first decode slot is killed
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o  <= `RS5_RESET_PC;
            tag_o <= '1;
        end else if (enable_i) begin
            pc_o  <= pc;
            tag_o <= tag;
        end
    end

endmodule

`default_nettype wire

/* design/rs5_decode.sv */
//////////////////////////////
// RS5 decode stage
// Opcode decode, immediates, operand select,
// RAW hazard detection and the execute stage register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_consts.svh"

module rs5_decode (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  rs5_pkg::word_t      instruction_i,
    input  rs5_pkg::word_t      pc_i,
    input  rs5_pkg::tag_t       tag_i,
    input  rs5_pkg::word_t      rs1_data_i,
    input  rs5_pkg::word_t      rs2_data_i,
    output rs5_pkg::reg_addr_t  rs1_o,
    output rs5_pkg::reg_addr_t  rs2_o,
    output rs5_pkg::iop_e       operation_o,
    output rs5_pkg::word_t      first_operand_o,
    output rs5_pkg::word_t      second_operand_o,
    output rs5_pkg::word_t      store_data_o,
    output rs5_pkg::reg_addr_t  rd_o,
    output logic                write_enable_o,
    output rs5_pkg::word_t      pc_o,
    output rs5_pkg::tag_t       tag_o,
    output logic                hazard_o
);
    import rs5_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    reg_addr_t  rd;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    iop_e       op;
    logic       uses_rs1, uses_rs2, writes_rd;
    word_t      first_operand, second_operand, third_operand;

    //////////////////////////////
    // Fields and immediates
    //////////////////////////////

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    // SUB and SRA select
    assign alt    = instruction_i[30];
    assign rd     = instruction_i[11:7];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

    //////////////////////////////
    // Operation decode
    //////////////////////////////

    always_comb begin
        op        = NOP;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            `RS5_OP_OP, `RS5_OP_OPIMM: begin
                uses_rs1  = 1'b1;
                uses_rs2  = (opcode == `RS5_OP_OP);
                writes_rd = 1'b1;
                case (funct3)
                    3'b000:  op = (alt && opcode == `RS5_OP_OP) ? SUB : ADD;
                    3'b001:  op = SLL;
                    3'b010:  op = SLT;
                    3'b100:  op = XOR;
                    3'b101:  op = alt ? SRA : SRL;
                    3'b110:  op = OR;
                    3'b111:  op = AND;
                    // SLTU not supported
                    default: op = NOP;
                endcase
            end
            `RS5_OP_LUI: begin
                op        = LUI;
                writes_rd = 1'b1;
            end
            `RS5_OP_LOAD: begin
                // Word loads only
                op        = (funct3 == 3'b010) ? LOAD : NOP;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            `RS5_OP_STORE: begin
                op       = (funct3 == 3'b010) ? STORE : NOP;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            `RS5_OP_BRANCH: begin
                op       = (funct3 == 3'b000) ? BEQ : (funct3 == 3'b001) ? BNE : NOP;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            `RS5_OP_JAL: begin
                op        = JAL;
                writes_rd = 1'b1;
            end
            default: op = NOP;
        endcase
    end

    //////////////////////////////
    // Operand select
    //////////////////////////////

    // Third operand is the store data or the jump offset
    always_comb begin
        first_operand  = rs1_data_i;
        second_operand = rs2_data_i;
        third_operand  = rs2_data_i;
        case (opcode)
            `RS5_OP_OPIMM, `RS5_OP_LOAD: second_operand = imm_i;
            `RS5_OP_STORE:               second_operand = imm_s;
            `RS5_OP_LUI:                 second_operand = imm_u;
            `RS5_OP_BRANCH:              third_operand  = imm_b;
            `RS5_OP_JAL:                 third_operand  = imm_j;
            default:                     second_operand = rs2_data_i;
        endcase
    end

    // Producer in execute has no result before retire
    assign hazard_o = write_enable_o &&
                      ((uses_rs1 && rs1_o == rd_o) || (uses_rs2 && rs2_o == rd_o));

    //////////////////////////////
    // Execute stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            operation_o    <= NOP;
            write_enable_o <= 1'b0;
            tag_o          <= '0;
        end else if (!stall_i) begin
            // Hazard sends a bubble while fetch holds
            operation_o    <= hazard_o ? NOP : op;
            // x0 is never written
            write_enable_o <= !hazard_o && writes_rd && op != NOP && rd != '0;
            tag_o          <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            store_data_o     <= third_operand;
            rd_o             <= rd;
            pc_o             <= pc_i;
        end
    end

endmodule

`default_nettype wire

/* design/rs5_regbank.sv */
//////////////////////////////
// RS5 register bank
// Flip-flop registers x1 to x31 with two async reads
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_consts.svh"

module rs5_regbank (
    input  logic               clk,
    input  logic               rst_n_i,
    input  rs5_pkg::reg_addr_t rs1_i,
    input  rs5_pkg::reg_addr_t rs2_i,
    input  rs5_pkg::reg_addr_t rd_i,
    input  logic               write_enable_i,
    input  rs5_pkg::word_t     data_i,
    output rs5_pkg::word_t     data1_o,
    output rs5_pkg::word_t     data2_o
);
    import rs5_pkg::*;

    // No storage behind x0
    word_t regs [`RS5_REG_COUNT-1:1];

    always_ff @(posedge clk) begin
        for (int i = 1; i < `RS5_REG_COUNT; i++) begin
            if (!rst_n_i) begin
                regs[i] <= '0;
            end else if (write_enable_i && rd_i == reg_addr_t'(i)) begin
                regs[i] <= data_i;
            end
        end
    end

    // Index 0 reads as zero
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* design/rs5_execute.sv */
//////////////////////////////
// RS5 execute stage
// ALU, branch resolution, memory request
// and the retire stage register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rs5_execute (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  rs5_pkg::iop_e      operation_i,
    input  rs5_pkg::word_t     first_operand_i,
    input  rs5_pkg::word_t     second_operand_i,
    input  rs5_pkg::word_t     store_data_i,
    input  rs5_pkg::reg_addr_t rd_i,
    input  logic               write_enable_i,
    input  rs5_pkg::word_t     pc_i,
    input  rs5_pkg::tag_t      tag_i,
    output logic               jump_o,
    output rs5_pkg::word_t     jump_target_o,
    output logic               mem_operation_enable_o,
    output rs5_pkg::byte_en_t  mem_write_enable_o,
    output rs5_pkg::word_t     mem_address_o,
    output rs5_pkg::word_t     mem_data_o,
    output rs5_pkg::iop_e      operation_o,
    output rs5_pkg::word_t     result_o,
    output rs5_pkg::reg_addr_t rd_o,
    output logic               write_enable_o
);
    import rs5_pkg::*;

    tag_t  current_tag;
    logic  valid;
    logic  equal;
    logic  taken;
    word_t sum;
    word_t result;

    // Wrong-path instructions still carry the old tag
    assign valid = (tag_i == current_tag);
    assign sum   = first_operand_i + second_operand_i;
    assign equal = (first_operand_i == second_operand_i);

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (operation_i)
            ADD, LOAD, STORE: result = sum;
            SUB:     result = first_operand_i - second_operand_i;
            AND:     result = first_operand_i & second_operand_i;
            OR:      result = first_operand_i | second_operand_i;
            XOR:     result = first_operand_i ^ second_operand_i;
            SLT:     result = word_t'($signed(first_operand_i) < $signed(second_operand_i));
            SLL:     result = first_operand_i << second_operand_i[4:0];
            SRL:     result = first_operand_i >> second_operand_i[4:0];
            SRA:     result = word_t'($signed(first_operand_i) >>> second_operand_i[4:0]);
            LUI:     result = second_operand_i;
            // Link address
            JAL:     result = pc_i + 32'd4;
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Branch and jump
    //////////////////////////////

    always_comb begin
        case (operation_i)
            BEQ:     taken = equal;
            BNE:     taken = !equal;
            JAL:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // One-shot while stalled so fetch and tag move once
    assign jump_o        = valid && taken && !stall_i;
    // Offset comes on the store data path
    assign jump_target_o = pc_i + store_data_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            current_tag <= '0;
        end else if (jump_o) begin
            current_tag <= current_tag + 1'b1;
        end
    end

    //////////////////////////////
    // Data memory request
    //////////////////////////////

    // Issued in the cycle the instruction leaves execute
    assign mem_operation_enable_o = valid && !stall_i &&
                                    (operation_i == LOAD || operation_i == STORE);
    assign mem_write_enable_o     = (mem_operation_enable_o && operation_i == STORE)
                                    ? '1 : '0;
    assign mem_address_o          = sum;
    assign mem_data_o             = store_data_i;

    //////////////////////////////
    // Retire stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            operation_o    <= NOP;
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            // Killed slots retire as NOP
            operation_o    <= valid ? operation_i : NOP;
            write_enable_o <= valid && write_enable_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result;
            rd_o     <= rd_i;
        end
    end

endmodule

`default_nettype wire

/* design/rs5_core.sv */
//////////////////////////////
// RS5 core top level
// Stage wiring, write-back select and register bypass
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rs5_core (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  rs5_pkg::word_t    instruction_i,
    input  rs5_pkg::word_t    mem_data_i,
    output rs5_pkg::word_t    instruction_address_o,
    output logic              mem_operation_enable_o,
    output rs5_pkg::byte_en_t mem_write_enable_o,
    output rs5_pkg::word_t    mem_address_o,
    output rs5_pkg::word_t    mem_data_o
);
    import rs5_pkg::*;

    //////////////////////////////
    // Stage signals
    //////////////////////////////

    // Fetch
    logic      enable_fetch;
    logic      jump;
    word_t     jump_target;
    word_t     pc_decode;
    tag_t      tag_decode;

    // Decode and register read
    logic      hazard;
    reg_addr_t rs1, rs2;
    word_t     regbank_data1, regbank_data2;
    word_t     rs1_data, rs2_data;

    // Execute
    iop_e      operation_execute;
    word_t     first_operand_execute, second_operand_execute, store_data_execute;
    reg_addr_t rd_execute;
    logic      write_enable_execute;
    word_t     pc_execute;
    tag_t      tag_execute;

    // Retire
    iop_e      operation_retire;
    word_t     result_retire;
    reg_addr_t rd_retire;
    logic      write_enable_retire;
    word_t     writeback_data;

    // Hazard holds fetch while execute takes a bubble
    assign enable_fetch = !(stall_i || hazard);

    // Loads take the memory word
    assign writeback_data = (operation_retire == LOAD) ? mem_data_i : result_retire;

    // Retiring value bypasses the bank write
    assign rs1_data = (write_enable_retire && rs1 == rd_retire) ? writeback_data
                                                                : regbank_data1;
    assign rs2_data = (write_enable_retire && rs2 == rd_retire) ? writeback_data
                                                                : regbank_data2;

    //////////////////////////////
    // Pipeline stages
    //////////////////////////////

    rs5_fetch fetch_i (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .enable_i              (enable_fetch),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    rs5_decode decode_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .instruction_i    (instruction_i),
        .pc_i             (pc_decode),
        .tag_i            (tag_decode),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .operation_o      (operation_execute),
        .first_operand_o  (first_operand_execute),
        .second_operand_o (second_operand_execute),
        .store_data_o     (store_data_execute),
        .rd_o             (rd_execute),
        .write_enable_o   (write_enable_execute),
        .pc_o             (pc_execute),
        .tag_o            (tag_execute),
        .hazard_o         (hazard)
    );

    rs5_regbank regbank_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rd_i           (rd_retire),
        .write_enable_i (write_enable_retire),
        .data_i         (writeback_data),
        .data1_o        (regbank_data1),
        .data2_o        (regbank_data2)
    );

    rs5_execute execute_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .operation_i            (operation_execute),
        .first_operand_i        (first_operand_execute),
        .second_operand_i       (second_operand_execute),
        .store_data_i           (store_data_execute),
        .rd_i                   (rd_execute),
        .write_enable_i         (write_enable_execute),
        .pc_i                   (pc_execute),
        .tag_i                  (tag_execute),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .operation_o            (operation_retire),
        .result_o               (result_retire),
        .rd_o                   (rd_retire),
        .write_enable_o         (write_enable_retire)
    );

endmodule

`default_nettype wire

/* tb/tb_rs5_core.sv */
//////////////////////////////
// RS5 core testbench
// Instruction and data memory models, random stall,
// ordered store checking against the patterns file
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rs5_consts.svh"

module tb_rs5_core;
    import rs5_pkg::*;

    logic      clk;
    logic      rst_n_i;
    logic      stall_i;
    word_t     instruction_i;
    word_t     mem_data_i;
    word_t     instruction_address_o;
    logic      mem_operation_enable_o;
    byte_en_t  mem_write_enable_o;
    word_t     mem_address_o;
    word_t     mem_data_o;

    // Memories and expected stores
    word_t     imem [0:63];
    word_t     dmem [0:255];
    word_t     exp_addr [$];
    word_t     exp_data [$];
    int        prog_len;
    int        exp_index;
    int        error_count;
    int        check_count;
    logic      end_seen;
    logic      aborted;
    logic      stall_random;
    word_t     fetch_addr;
    logic      read_pending;
    word_t     read_word;
    logic [31:0] lfsr;

    rs5_core dut_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        word_t       a;
        word_t       b;
        fd = $fopen("tb/rs5_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            aborted = 1'b1;
            $display("Cannot open the pattern file tb/rs5_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%c %h %h", kind, a, b);
                    if (kind == "I" && n >= 2 && prog_len < 64) begin
                        imem[prog_len] = a;
                        prog_len++;
                    end else if (kind == "S" && n == 3) begin
                        exp_addr.push_back(a);
                        exp_data.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Word value tied to its own address
    task automatic fill_data_memory();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {16'hd00d, 14'(i), 2'b00};
        end
    endtask

    task automatic observe_store(input word_t addr, input word_t data);
        if (exp_index >= exp_addr.size()) begin
            error_count++;
            $display("Unexpected extra store of %h to address %h at %0t", data, addr, $time);
        end else begin
            check_value("store address", addr, exp_addr[exp_index]);
            check_value("store data", data, exp_data[exp_index]);
            exp_index++;
        end
        // Address 0x100 marks the end of the program
        if (addr == 32'h100) begin
            end_seen = 1'b1;
        end
    endtask

    //////////////////////////////
    // Memory and stall models
    //////////////////////////////

    // Bus sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        fetch_addr   = instruction_address_o;
        read_pending = 1'b0;
        if (rst_n_i && mem_operation_enable_o) begin
            if (mem_write_enable_o == 4'hf) begin
                observe_store(mem_address_o, mem_data_o);
                dmem[mem_address_o[9:2]] = mem_data_o;
            end else begin
                // Loads carry no byte enables
                check_value("load write enable", word_t'(mem_write_enable_o), '0);
                read_pending = 1'b1;
                read_word    = dmem[mem_address_o[9:2]];
            end
        end
    end

    always @(posedge clk) begin
        logic first_bit;
        #1;
        instruction_i = imem[fetch_addr[7:2]];
        if (read_pending) begin
            mem_data_i = read_word;
        end
        if (stall_random) begin
            lfsr      = lfsr_step(lfsr);
            first_bit = lfsr[0];
            lfsr      = lfsr_step(lfsr);
            stall_i   = first_bit && lfsr[0];
        end else begin
            stall_i = 1'b0;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    task automatic run_program(input logic use_stall);
        int cycles;
        int limit;
        limit = 4 * prog_len + 200;
        @(posedge clk);
        #1;
        rst_n_i   = 1'b0;
        end_seen  = 1'b0;
        exp_index = 0;
        fill_data_memory();
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        // First fetch comes out of reset at zero
        @(negedge clk);
        check_value("address after reset", instruction_address_o, `RS5_RESET_PC);
        check_value("memory enable after reset", {31'b0, mem_operation_enable_o}, '0);
        stall_random = use_stall;
        cycles = 0;
        while (!end_seen && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!end_seen) begin
            error_count++;
            aborted = 1'b1;
            $display("Timeout: no end store within %0d cycles", limit);
        end else begin
            check_value("number of stores", exp_index, exp_addr.size());
        end
        @(negedge clk);
        stall_random = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        fetch_addr    = '0;
        read_pending  = 1'b0;
        read_word     = '0;
        stall_random  = 1'b0;
        end_seen      = 1'b0;
        aborted       = 1'b0;
        lfsr          = 32'h2a0c0d23;
        prog_len      = 0;
        exp_index     = 0;
        error_count   = 0;
        check_count   = 0;
        // Unused slots hold addi x0, x0, 0
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0013;
        end
        load_patterns();
        if (!aborted) begin
            run_program(1'b0);
        end
        if (!aborted) begin
            run_program(1'b1);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rs5_core.f */
+incdir+design
design/rs5_pkg.sv
design/rs5_fetch.sv
design/rs5_decode.sv
design/rs5_regbank.sv
design/rs5_execute.sv
design/rs5_core.sv
tb/tb_rs5_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RS5 core testbench with Verilator.
# The pass or fail result is taken from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f rs5_core.f --top-module tb_rs5_core \
    --Mdir "$BUILD_DIR" -o tb_rs5_core
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/tb_rs5_core" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* tb/rs5_patterns.txt */
# I <word> [asm]  program word, stored from address 0 upward
# S <addr> <data>  expected store, in program order
I 800010B7 lui  x1, 0x80001
I 12300113 addi x2, x0, 0x123
I 002081B3 add  x3, x1, x2
I 4041D213 srai x4, x3, 4
I FFF24293 xori x5, x4, -1
I 40228333 sub  x6, x5, x2
I 00602023 sw   x6, 0(x0)
I 002223B3 slt  x7, x4, x2
I 00711433 sll  x8, x2, x7
I 00C0D493 srli x9, x1, 12
I 00946533 or   x10, x8, x9
I 005575B3 and  x11, x10, x5
I 00558013 addi x0, x11, 5
I 00B02223 sw   x11, 4(x0)
I 00002423 sw   x0, 8(x0)
I 04002683 lw   x13, 0x40(x0)
I 00268733 add  x14, x13, x2
I 00E02623 sw   x14, 12(x0)
I 00210463 beq  x2, x2, +8
I 00202823 sw   x2, 0x10(x0)
I 00011463 bne  x2, x0, +8
I 00202A23 sw   x2, 0x14(x0)
I 008007EF jal  x15, +8
I 00202C23 sw   x2, 0x18(x0)
I 00F02E23 sw   x15, 0x1C(x0)
I 10202023 sw   x2, 0x100(x0)
I 0000006F jal  x0, 0
S 00000000 07FFFDCA
S 00000004 00080245
S 00000008 00000000
S 0000000C D00D0163
S 0000001C 0000005C
S 00000100 00000123
